// File: sdCardResponder.f
+incdir+rtl
rtl/sdCardPkg.sv
rtl/sdCmdRxIf.sv
rtl/sdRespTxIf.sv
rtl/sdCrc7.sv
rtl/sdCmdRx.sv
rtl/sdCardCtrl.sv
rtl/sdRespTx.sv
rtl/sdCardResponder.sv
bench/tbSdCard.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sdCardResponder.f \
    --top-module tbSdCard -o simTbSdCard
./obj_dir/simTbSdCard | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

// File: bench/tbSdCard.sv
`timescale 1ns/1ps
`include "sdCardParams.svh"

module tbSdCard;
    localparam int NumEcho = 4;
    // Frames sent by the main sequence
    localparam int NumFrames = 29;
    localparam int WatchdogCycles = NumFrames * (48 + 136 + 20) + 10 + 200;
    localparam int RespWait = `SD_NCR_CYCLES + 12;

    logic clk;
    logic rst_;
    logic cmdIn;
    logic cmdOut;
    logic cmdOe;
    logic cmdError;

    int cycleCount = 0;
    int lastEndCycle = 0;
    int errPulses = 0;
    int errMark = 0;
    int lastErrCycle = 0;
    int errCount = 0;
    int checkCount = 0;

    sdCardResponder u_dut (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe),
        .cmdError (cmdError)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Rising edge count is read at the falling edge after it
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    always @(negedge clk) begin
        if (rst_ && cmdError) begin
            errPulses++;
            lastErrCycle = cycleCount;
        end
    end

    // ========================================
    // Assertions
    // ========================================
    assert property (@(posedge clk) !rst_ |=> !cmdOe)
    else begin
        errCount++;
        $display("ERR %0t cmdOe expected 0 got 1", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_) cmdError |=> !cmdError)
    else begin
        errCount++;
        $display("cmdError stayed high for more than one cycle at %0t", $time);
    end

    // CRC7 model over x^7 + x^3 + 1 with the MSB first
    function automatic logic [6:0] crc7Of(input logic [39:0] head);
        logic [6:0] crc;
        logic       fb;
        int         i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            fb = head[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    task automatic checkValue(input string name, input logic [135:0] got,
                              input logic [135:0] exp);
        checkCount++;
        assert (got === exp)
        else begin
            errCount++;
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checkCount++;
        assert (cond)
        else begin
            errCount++;
            $display("At %0t: %s", $time, what);
        end
    endtask

    // ========================================
    // Host side
    // ========================================
    task automatic sendFrame(input logic [5:0] index, input logic [31:0] arg,
                             input logic badCrc, input logic badPreamble);
        logic [39:0] head;
        logic [6:0]  crc;
        logic [47:0] frame;
        int          i;
        head = {1'b0, ~badPreamble, index, arg};
        crc = crc7Of(head);
        if (badCrc) begin
            crc[0] = ~crc[0];
        end
        frame = {head, crc, 1'b1};
        repeat (2) @(posedge clk);
        errMark = errPulses;
        for (i = 47; i >= 0; i--) begin
            @(posedge clk);
            cmdIn <= frame[i];
        end
        // Card samples the end bit on this edge
        @(posedge clk);
        cmdIn <= 1'b1;
        @(negedge clk);
        lastEndCycle = cycleCount;
    endtask

    task automatic captureResponse(input int waitLimit, output logic seen,
                                   output logic [135:0] bits, output int len,
                                   output int riseCycle);
        int waited;
        seen = 1'b0;
        bits = '0;
        len = 0;
        riseCycle = 0;
        waited = 0;
        while (!cmdOe && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (cmdOe) begin
            seen = 1'b1;
            riseCycle = cycleCount;
            while (cmdOe && len < 200) begin
                bits = {bits[134:0], cmdOut};
                len++;
                @(negedge clk);
            end
        end
    endtask

    task automatic checkErrorPulse(input int expected);
        checkValue("cmdError pulses", errPulses - errMark, expected);
        if (expected != 0) begin
            checkValue("cmdError cycle", lastErrCycle - lastEndCycle, 1);
        end
    endtask

    // R1 or R3 response where R3 has seven 1s in the CRC field
    task automatic expectShort(input logic [5:0] idx, input logic [31:0] arg,
                               input logic isR3);
        logic         seen;
        logic [135:0] bits;
        int           len;
        int           riseCycle;
        logic [6:0]   expCrc;
        captureResponse(RespWait, seen, bits, len, riseCycle);
        checkTrue(seen, "no short response on the CMD line");
        if (seen) begin
            expCrc = isR3 ? 7'h7f : crc7Of({2'b01, idx, arg});
            checkValue("response length", len, 48);
            checkValue("response head", bits[47:46], 2'b01);
            checkValue("response index", bits[45:40], idx);
            checkValue("response argument", bits[39:8], arg);
            checkValue("response crc", bits[7:1], expCrc);
            checkValue("response end bit", bits[0], 1'b1);
            checkValue("cmdOe rise delay", riseCycle - lastEndCycle, `SD_NCR_CYCLES + 2);
        end
        checkErrorPulse(0);
    endtask

    task automatic expectLong();
        logic         seen;
        logic [135:0] bits;
        int           len;
        int           riseCycle;
        captureResponse(RespWait, seen, bits, len, riseCycle);
        checkTrue(seen, "no long response on the CMD line");
        if (seen) begin
            checkValue("R2 length", len, `SD_R2_BITS);
            checkValue("R2 word", bits, `SD_CID_RESPONSE);
            checkValue("cmdOe rise delay", riseCycle - lastEndCycle, `SD_NCR_CYCLES + 2);
        end
        checkErrorPulse(0);
    endtask

    task automatic expectNone(input int errExpected);
        logic         seen;
        logic [135:0] bits;
        int           len;
        int           riseCycle;
        captureResponse(RespWait, seen, bits, len, riseCycle);
        checkTrue(!seen, "card answered a frame that needs no response");
        checkErrorPulse(errExpected);
    endtask

    task automatic checkEcho(input logic [31:0] arg);
        sendFrame(6'd8, arg, 1'b0, 1'b0);
        expectShort(6'd8, arg, 1'b0);
    endtask

    // CMD55 then ACMD41
    task automatic requestOcr(input logic [31:0] ocr);
        sendFrame(6'd55, 32'h0, 1'b0, 1'b0);
        expectShort(6'd55, 32'h00000120, 1'b0);
        sendFrame(6'd41, 32'h40ff8000, 1'b0, 1'b0);
        expectShort(6'h3f, ocr, 1'b1);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int i;
        void'($urandom(32'h5d52));
        rst_ = 1'b0;
        cmdIn = 1'b1;
        repeat (10) @(posedge clk);
        rst_ <= 1'b1;
        repeat (3) @(posedge clk);

        // Idle card without an RCA yet
        sendFrame(6'd0, 32'h0, 1'b0, 1'b0);
        expectNone(0);
        sendFrame(6'd7, {`SD_CARD_RCA, 16'h0}, 1'b0, 1'b0);
        expectNone(1);

        for (i = 0; i < NumEcho; i++) begin
            checkEcho($urandom());
        end

        sendFrame(6'd2, 32'h0, 1'b0, 1'b0);
        expectLong();
        sendFrame(6'd3, 32'h0, 1'b0, 1'b0);
        expectShort(6'd3, {`SD_CARD_RCA, 16'h0520}, 1'b0);
        sendFrame(6'd7, {`SD_CARD_RCA, 16'h1234}, 1'b0, 1'b0);
        expectShort(6'd7, 32'h00000700, 1'b0);

        // Application prefix
        sendFrame(6'd6, 32'h2, 1'b0, 1'b0);
        expectShort(6'd6, 32'h00000900, 1'b0);
        sendFrame(6'd55, {`SD_CARD_RCA, 16'h0}, 1'b0, 1'b0);
        expectShort(6'd55, 32'h00000120, 1'b0);
        sendFrame(6'd6, 32'h2, 1'b0, 1'b0);
        expectShort(6'd6, 32'h00000920, 1'b0);
        requestOcr(`SD_OCR_BUSY);
        requestOcr(`SD_OCR_READY);
        requestOcr(`SD_OCR_READY);
        sendFrame(6'd0, 32'h0, 1'b0, 1'b0);
        expectNone(0);
        requestOcr(`SD_OCR_BUSY);

        // Each broken frame is followed by a good one
        sendFrame(6'd8, 32'h000001aa, 1'b1, 1'b0);
        expectNone(1);
        checkEcho(32'h000001aa);
        sendFrame(6'd8, 32'h000001aa, 1'b0, 1'b1);
        expectNone(1);
        checkEcho($urandom());
        sendFrame(6'd17, 32'h0, 1'b0, 1'b0);
        expectNone(1);
        checkEcho($urandom());
        // ACMD41 index without CMD55 is unknown
        sendFrame(6'd41, 32'h40ff8000, 1'b0, 1'b0);
        expectNone(1);
        checkEcho($urandom());

        $display("Checks: %0d, errors: %0d, cmdError pulses: %0d",
                 checkCount, errCount, errPulses);
        if (errCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * 20);
        $display("Timeout: run did not finish within %0d cycles, errors: %0d",
                 WatchdogCycles, errCount);
        $display("TEST FAILED");
        $finish;
    end
endmodule

// File: rtl/sdCardResponder.sv
`timescale 1ns/1ps

module sdCardResponder (
    input  logic clk,
    input  logic rst_,
    input  logic cmdIn,
    output logic cmdOut,
    output logic cmdOe,
    output logic cmdError
);
    // ========================================
    // Internal links
    // ========================================
    sdCmdRxIf  cmdLink ();
    sdRespTxIf respLink ();

    // Host command frames in
    sdCmdRx u_cmdRx (
        .clk   (clk),
        .rst_  (rst_),
        .cmdIn (cmdIn),
        .rx    (cmdLink.rx)
    );

    // Card state and decode
    sdCardCtrl u_cardCtrl (
        .clk      (clk),
        .rst_     (rst_),
        .rx       (cmdLink.ctrl),
        .tx       (respLink.ctrl),
        .cmdError (cmdError)
    );

    // Responses out
    sdRespTx u_respTx (
        .clk    (clk),
        .rst_   (rst_),
        .tx     (respLink.tx),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe)
    );
endmodule

// File: rtl/sdRespTx.sv
`timescale 1ns/1ps
`include "sdCardParams.svh"

module sdRespTx (
    input  logic   clk,
    input  logic   rst_,
    sdRespTxIf.tx  tx,
    output logic   cmdOut,
    output logic   cmdOe
);
    localparam int CntW = $clog2(`SD_R2_BITS + 1);
    localparam int Msb = `SD_R2_BITS - 1;

    logic [`SD_R2_BITS-1:0]    shiftReg;
    sdCardPkg::sdRespKind_e    kind;
    logic [CntW-1:0]           bitCnt;
    logic [CntW-1:0]           frameLen;
    logic                      start;
    logic                      lastBit;
    logic                      crcSlot;
    logic                      crcEn;
    logic                      crcDin;
    logic [`SD_CRC7_BITS-1:0]  crc;
    logic [`SD_CRC7_BITS-1:0]  tail;

    assign start = tx.respStart && !cmdOe;
    assign frameLen = (kind == sdCardPkg::respR2) ? CntW'(`SD_R2_BITS) : CntW'(`SD_CMD_BITS);
    assign lastBit = (bitCnt == frameLen);

    // Head done, CRC or the R3 filler goes next
    assign crcSlot = (kind != sdCardPkg::respR2) && (bitCnt == CntW'(`SD_HEAD_BITS));
    assign tail = (kind == sdCardPkg::respR3) ? '1 : crc;

    // ========================================
    // CRC over the 40 head bits
    // ========================================
    assign crcEn = start || (cmdOe && bitCnt < CntW'(`SD_HEAD_BITS));
    assign crcDin = start ? tx.respWord[Msb] : shiftReg[Msb];

    sdCrc7 u_crc (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (start),
        .enable (crcEn),
        .din    (crcDin),
        .crc    (crc)
    );

    // ========================================
    // Serializer
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            cmdOe <= 1'b0;
            cmdOut <= 1'b0;
            bitCnt <= '0;
        end else if (start) begin
            cmdOe <= 1'b1;
            cmdOut <= tx.respWord[Msb];
            bitCnt <= CntW'(1);
        end else if (cmdOe) begin
            if (lastBit) begin
                cmdOe <= 1'b0;
                cmdOut <= 1'b0;
            end else if (crcSlot) begin
                cmdOut <= tail[`SD_CRC7_BITS-1];
            end else begin
                cmdOut <= shiftReg[Msb];
            end
            bitCnt <= bitCnt + 1'b1;
        end
    end

    // Rest of the tail and the end bit refill the top of the shifter
    always_ff @(posedge clk) begin
        if (start) begin
            shiftReg <= tx.respWord << 1;
            kind <= tx.respKind;
        end else if (cmdOe) begin
            if (crcSlot) begin
                shiftReg <= {tail[`SD_CRC7_BITS-2:0], 1'b1,
                             {(`SD_R2_BITS - `SD_CRC7_BITS){1'b0}}};
            end else begin
                shiftReg <= shiftReg << 1;
            end
        end
    end

    assign tx.respBusy = cmdOe;
endmodule

// File: rtl/sdCardCtrl.sv
`timescale 1ns/1ps
`include "sdCardParams.svh"

module sdCardCtrl (
    input  logic     clk,
    input  logic     rst_,
    sdCmdRxIf.ctrl   rx,
    sdRespTxIf.ctrl  tx,
    output logic     cmdError
);
    localparam int NcrW = $clog2(`SD_NCR_CYCLES + 1);

    sdCardPkg::sdCmd_e       cmd;
    sdCardPkg::sdRespKind_e  kind;
    sdCardPkg::sdRespKind_e  respKindReg;
    logic [`SD_R2_BITS-1:0]  respWordReg;
    logic [5:0]              respIndex;
    logic [31:0]             respArg;
    logic [15:0]             rca;
    logic                    appFlag;
    logic                    cardReady;
    logic                    known;
    logic                    needResp;
    logic                    rcaMismatch;
    logic                    busyDrop;
    logic                    accept;
    logic                    pending;
    logic [NcrW-1:0]         ncrCnt;
    logic                    respStart;

    assign cmd = sdCardPkg::sdCmd_e'({appFlag, rx.cmdIndex});

    // ========================================
    // Command decode
    // ========================================
    always_comb begin
        known = 1'b1;
        needResp = 1'b1;
        kind = sdCardPkg::respR1;
        respIndex = rx.cmdIndex;
        respArg = 32'h0;
        case (cmd)
            sdCardPkg::CMD0: needResp = 1'b0;
            sdCardPkg::CMD2: kind = sdCardPkg::respR2;
            sdCardPkg::CMD3: respArg = {`SD_CARD_RCA, 16'h0520};
            sdCardPkg::CMD6: respArg = 32'h00000900;
            sdCardPkg::CMD7: respArg = 32'h00000700;
            sdCardPkg::CMD8: respArg = rx.arg.raw;
            sdCardPkg::CMD55: respArg = 32'h00000120;
            sdCardPkg::ACMD6: respArg = 32'h00000920;
            sdCardPkg::ACMD41: begin
                kind = sdCardPkg::respR3;
                respIndex = 6'h3f;
                respArg = cardReady ? `SD_OCR_READY : `SD_OCR_BUSY;
            end
            default: begin
                known = 1'b0;
                needResp = 1'b0;
            end
        endcase
    end

    assign rcaMismatch = (cmd == sdCardPkg::CMD7) && (rx.arg.rcaView.rca != rca);
    // A response still waiting or on the line drops the new frame
    assign busyDrop = tx.respBusy || pending;
    assign accept = rx.frameValid && !busyDrop && rx.framingOk && rx.crcOk && known
                    && !rcaMismatch;

    // ========================================
    // Card state
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            rca <= 16'h0;
            appFlag <= 1'b0;
            cardReady <= 1'b0;
            cmdError <= 1'b0;
        end else begin
            cmdError <= rx.frameValid && !accept;
            if (accept) begin
                appFlag <= (cmd == sdCardPkg::CMD55);
                case (cmd)
                    sdCardPkg::CMD0: begin
                        rca <= 16'h0;
                        cardReady <= 1'b0;
                    end
                    sdCardPkg::CMD3: rca <= `SD_CARD_RCA;
                    // Busy once, ready from then on
                    sdCardPkg::ACMD41: cardReady <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // NCR wait, respStart lands SD_NCR_CYCLES+1 cycles after frameValid
    always_ff @(posedge clk) begin
        if (!rst_) begin
            pending <= 1'b0;
            ncrCnt <= '0;
            respStart <= 1'b0;
        end else begin
            respStart <= 1'b0;
            if (accept && needResp) begin
                pending <= 1'b1;
                ncrCnt <= NcrW'(`SD_NCR_CYCLES - 1);
            end else if (pending) begin
                if (ncrCnt == '0) begin
                    pending <= 1'b0;
                    respStart <= 1'b1;
                end else begin
                    ncrCnt <= ncrCnt - 1'b1;
                end
            end
        end
    end

    // Response payload, head is start, direction, index, argument
    always_ff @(posedge clk) begin
        if (accept && needResp) begin
            respKindReg <= kind;
            if (kind == sdCardPkg::respR2) begin
                respWordReg <= `SD_CID_RESPONSE;
            end else begin
                respWordReg <= {2'b01, respIndex, respArg,
                                {(`SD_R2_BITS - `SD_HEAD_BITS){1'b0}}};
            end
        end
    end

    assign tx.respStart = respStart;
    assign tx.respKind = respKindReg;
    assign tx.respWord = respWordReg;
endmodule

// File: rtl/sdCmdRx.sv
`timescale 1ns/1ps
`include "sdCardParams.svh"

module sdCmdRx (
    input  logic   clk,
    input  logic   rst_,
    input  logic   cmdIn,
    sdCmdRxIf.rx   rx
);
    localparam int CntW = $clog2(`SD_CMD_BITS);
    localparam int ArgLsb = `SD_CRC7_BITS + 1;

    logic                     active;
    logic [CntW-1:0]          bitCnt;
    logic [`SD_CMD_BITS-1:0]  frame;
    logic                     frameValid;
    logic                     startBit;
    logic                     crcEn;
    logic [`SD_CRC7_BITS-1:0] crcCalc;

    // Line idles high, the first 0 is the start bit
    assign startBit = !active && !cmdIn;

    // bitCnt holds the bits already taken, so this covers bits 1 to 40
    assign crcEn = startBit || (active && bitCnt < CntW'(`SD_HEAD_BITS));

    sdCrc7 u_crc (
        .clk    (clk),
        .rst_   (rst_),
        .clear  (startBit),
        .enable (crcEn),
        .din    (cmdIn),
        .crc    (crcCalc)
    );

    // ========================================
    // Bit counter and frame strobe
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            active <= 1'b0;
            bitCnt <= '0;
            frameValid <= 1'b0;
        end else begin
            frameValid <= 1'b0;
            if (startBit) begin
                active <= 1'b1;
                bitCnt <= CntW'(1);
            end else if (active) begin
                // Last bit of the frame
                if (bitCnt == CntW'(`SD_CMD_BITS - 1)) begin
                    active <= 1'b0;
                    frameValid <= 1'b1;
                end
                bitCnt <= bitCnt + 1'b1;
            end
        end
    end

    // Frame shift register, MSB first
    always_ff @(posedge clk) begin
        if (startBit || active) begin
            frame <= {frame[`SD_CMD_BITS-2:0], cmdIn};
        end
    end

    // ========================================
    // Field split and checks
    // ========================================
    assign rx.frameValid = frameValid;
    assign rx.framingOk = (frame[`SD_CMD_BITS-1 -: 2] == 2'b01) && frame[0];
    assign rx.crcOk = (crcCalc == frame[`SD_CRC7_BITS:1]);
    assign rx.cmdIndex = frame[`SD_CMD_BITS-3 -: 6];
    assign rx.arg = frame[`SD_HEAD_BITS-1:ArgLsb];
endmodule

// File: rtl/sdCrc7.sv
`timescale 1ns/1ps
`include "sdCardParams.svh"

module sdCrc7 (
    input  logic                     clk,
    input  logic                     rst_,
    input  logic                     clear,
    input  logic                     enable,
    input  logic                     din,
    output logic [`SD_CRC7_BITS-1:0] crc
);
    logic [`SD_CRC7_BITS-1:0] base;
    logic                     fb;

    // Clear with enable restarts the sum with din as the first bit
    assign base = clear ? '0 : crc;
    assign fb = din ^ base[6];

    // x^7 + x^3 + 1
    always_ff @(posedge clk) begin
        if (!rst_) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {base[5:3], base[2] ^ fb, base[1:0], fb};
        end else if (clear) begin
            crc <= '0;
        end
    end
endmodule

// File: rtl/sdRespTxIf.sv
`timescale 1ns/1ps
`include "sdCardParams.svh"

interface sdRespTxIf;
    logic                     respStart;
    sdCardPkg::sdRespKind_e   respKind;
    logic [`SD_R2_BITS-1:0]   respWord;
    logic                     respBusy;

    // respStart is only pulsed while respBusy is low
    modport ctrl (output respStart, respKind, respWord, input respBusy);
    modport tx (input respStart, respKind, respWord, output respBusy);
endinterface

// File: rtl/sdCmdRxIf.sv
`timescale 1ns/1ps

interface sdCmdRxIf;
    logic                  frameValid;
    logic                  framingOk;
    logic                  crcOk;
    logic [5:0]            cmdIndex;
    sdCardPkg::sdCmdArg_u  arg;

    // Fields hold from the frameValid pulse until the next frame
    modport rx (output frameValid, framingOk, crcOk, cmdIndex, arg);
    modport ctrl (input frameValid, framingOk, crcOk, cmdIndex, arg);
endinterface

// File: rtl/sdCardPkg.sv
`include "sdCardParams.svh"

package sdCardPkg;

    // ========================================
    // Command codes
    // ========================================
    // Top bit marks an application command (after CMD55)
    typedef enum logic [6:0] {
        CMD0   = {1'b0, 6'd0},
        CMD2   = {1'b0, 6'd2},
        CMD3   = {1'b0, 6'd3},
        CMD6   = {1'b0, 6'd6},
        CMD7   = {1'b0, 6'd7},
        CMD8   = {1'b0, 6'd8},
        CMD55  = {1'b0, 6'd55},
        ACMD6  = {1'b1, 6'd6},
        ACMD41 = {1'b1, 6'd41}
    } sdCmd_e;

    // ========================================
    // Command argument
    // ========================================
    // Addressed commands carry the RCA in the upper half
    typedef struct packed {
        logic [15:0] rca;
        logic [15:0] stuff;
    } sdRcaArg_s;

    typedef union packed {
        logic [`SD_HEAD_BITS-9:0] raw;
        sdRcaArg_s                rcaView;
    } sdCmdArg_u;

    // ========================================
    // Response format
    // ========================================
    // R3 has all ones where the CRC would be
    typedef enum logic [1:0] {
        respR1,
        respR2,
        respR3
    } sdRespKind_e;

endpackage

// File: rtl/sdCardParams.svh
`ifndef SD_CARD_PARAMS_SVH
`define SD_CARD_PARAMS_SVH

// Frame lengths on the CMD line
`define SD_CMD_BITS      48
`define SD_R2_BITS       136
// Start, transmission bit, index and argument
`define SD_HEAD_BITS     40
`define SD_CRC7_BITS     7

// Idle cycles between frame acceptance and response start
`define SD_NCR_CYCLES    2

// Card identity
`define SD_CARD_RCA      16'hAAAA
`define SD_CID_RESPONSE  136'h3f0353445352313238808bb79d66014677

// R3 arguments, bit 31 is the power-up done flag
`define SD_OCR_BUSY      32'h00ff8080
`define SD_OCR_READY     32'hc1ff8080

`endif
